/* logic/fetch_pkg.sv */
package fetch_pkg;

  // Datapath widths
  localparam int XLEN = 32;
  localparam int ILEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [ILEN-1:0] instr_t;

  // Fetch restarts here after reset
  localparam xlen_t RESET_PC = 32'h0000_0100;

  // addi x0, x0, 0
  localparam instr_t I_NOP = 32'h0000_0013;

  // BTB geometry, index taken from PC[5:2]
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = 4;
  localparam int BTB_TAG_W   = XLEN - BTB_IDX_W - 2;

  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;

  // Return stack geometry
  localparam int RAS_DEPTH = 4;
  localparam int RAS_PTR_W = 2;
  // Count must reach RAS_DEPTH itself
  localparam int RAS_CNT_W = RAS_PTR_W + 1;

  typedef logic [RAS_PTR_W-1:0] ras_ptr_t;
  typedef logic [RAS_CNT_W-1:0] ras_cnt_t;

  // Predictor view of one fetch PC
  typedef struct packed {
    logic  btb_hit;
    logic  pred_taken;
    xlen_t btb_target;
    logic  is_return;
    logic  ras_valid;
    xlen_t ras_target;
  } pred_t;

  // Fetch to decode
  typedef struct packed {
    logic   valid;
    xlen_t  pc;
    xlen_t  pc_plus4;
    instr_t instr;
    pred_t  pred;
  } fetch_pkt_t;

  // Branch resolution from execute
  typedef struct packed {
    logic  valid;
    xlen_t pc;
    xlen_t target;
    logic  taken;
    logic  is_call;
    logic  is_return;
    // Mispredict, valid only with valid
    logic  redirect;
    xlen_t redirect_pc;
  } resolve_t;

endpackage

/* logic/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall,
  input  fetch_pkg::resolve_t resolve,
  input  fetch_pkg::xlen_t  next_pc_pred,
  output fetch_pkg::xlen_t  pc
);

  import fetch_pkg::*;

  logic  redirect;
  xlen_t pc_d;

  // Mispredict from execute
  assign redirect = resolve.valid && resolve.redirect;

  // Next PC select
  // Redirect beats stall, stall beats prediction
  always_comb begin
    if (redirect) begin
      pc_d = resolve.redirect_pc;
    end else if (stall) begin
      pc_d = pc;
    end else begin
      pc_d = next_pc_pred;
    end
  end

  // PC register
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_d;
    end
  end

endmodule

/* logic/branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer (
  input  logic                clk,
  input  logic                rst,
  input  fetch_pkg::xlen_t    pc,
  input  fetch_pkg::resolve_t resolve,
  output logic                hit,
  output logic                taken,
  output logic                is_return,
  output fetch_pkg::xlen_t    target
);

  import fetch_pkg::*;

  // Payload of one BTB line
  typedef struct packed {
    btb_tag_t tag;
    xlen_t    target;
    logic     taken;
    logic     is_return;
  } btb_entry_t;

  logic [BTB_ENTRIES-1:0] valid;
  btb_entry_t             entries [BTB_ENTRIES];

  btb_idx_t   rd_idx;
  btb_tag_t   rd_tag;
  btb_entry_t rd_entry;

  btb_idx_t wr_idx;
  btb_tag_t wr_tag;
  logic     wr_hit;
  logic     train;
  logic     untrain;

  // Lookup side, fetch PC
  assign rd_idx   = pc[BTB_IDX_W+1:2];
  assign rd_tag   = pc[XLEN-1:BTB_IDX_W+2];
  assign rd_entry = entries[rd_idx];

  assign hit       = valid[rd_idx] && (rd_entry.tag == rd_tag);
  // Flags only mean something on a hit
  assign taken     = hit && rd_entry.taken;
  assign is_return = hit && rd_entry.is_return;
  assign target    = rd_entry.target;

  // Training side, resolved PC
  assign wr_idx = resolve.pc[BTB_IDX_W+1:2];
  assign wr_tag = resolve.pc[XLEN-1:BTB_IDX_W+2];
  assign wr_hit = valid[wr_idx] && (entries[wr_idx].tag == wr_tag);

  // Returns always allocate as taken
  assign train   = resolve.valid && (resolve.taken || resolve.is_return);
  assign untrain = resolve.valid && !resolve.taken && !resolve.is_return && wr_hit;

  // Valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (train) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // Line write or taken clear
  always_ff @(posedge clk) begin
    if (train) begin
      entries[wr_idx].tag       <= wr_tag;
      entries[wr_idx].target    <= resolve.target;
      entries[wr_idx].taken     <= 1'b1;
      entries[wr_idx].is_return <= resolve.is_return;
    end else if (untrain) begin
      entries[wr_idx].taken <= 1'b0;
    end
  end

endmodule

/* logic/return_stack.sv */
`timescale 1ns/1ps

module return_stack (
  input  logic                clk,
  input  logic                rst,
  input  fetch_pkg::resolve_t resolve,
  output fetch_pkg::xlen_t    top,
  output logic                top_valid
);

  import fetch_pkg::*;

  xlen_t    stack [RAS_DEPTH];
  // Points at the current top entry
  ras_ptr_t ptr;
  ras_ptr_t push_ptr;
  ras_cnt_t count;
  logic     push;
  logic     pop;

  // A call that is also a return counts as a push only
  assign push = resolve.valid && resolve.is_call;
  // Pop on empty is ignored
  assign pop  = resolve.valid && resolve.is_return && !resolve.is_call && (count != '0);

  assign push_ptr = ptr + 1'b1;

  // Pointer and saturating depth
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr   <= '0;
      count <= '0;
    end else if (push) begin
      ptr <= push_ptr;
      // Full stack wraps onto its oldest entry
      if (count != RAS_CNT_W'(RAS_DEPTH)) begin
        count <= count + 1'b1;
      end
    end else if (pop) begin
      ptr   <= ptr - 1'b1;
      count <= count - 1'b1;
    end
  end

  // Return address of the call
  always_ff @(posedge clk) begin
    if (push) begin
      stack[push_ptr] <= resolve.pc + XLEN'(4);
    end
  end

  assign top       = stack[ptr];
  assign top_valid = (count != '0);

endmodule

/* logic/fetch_stage_sram.sv */
`timescale 1ns/1ps

module fetch_stage_sram (
  input  fetch_pkg::xlen_t      pc,
  output fetch_pkg::xlen_t      imem_raddr,
  input  fetch_pkg::instr_t     imem_rdata,
  input  logic                  btb_hit,
  input  logic                  btb_taken,
  input  logic                  btb_is_return,
  input  fetch_pkg::xlen_t      btb_target,
  input  logic                  ras_valid,
  input  fetch_pkg::xlen_t      ras_target,
  output fetch_pkg::fetch_pkt_t pkt,
  output fetch_pkg::xlen_t      next_pc_pred
);

  import fetch_pkg::*;

  xlen_t pc_plus4;
  pred_t pred;

  assign pc_plus4 = pc + XLEN'(4);

  // Zero-latency SRAM, data back in this cycle
  assign imem_raddr = pc;

  // Predictor snapshot for this PC
  assign pred.btb_hit    = btb_hit;
  assign pred.pred_taken = btb_taken;
  assign pred.btb_target = btb_target;
  assign pred.is_return  = btb_is_return;
  assign pred.ras_valid  = ras_valid;
  assign pred.ras_target = ras_target;

  // Packet to IF/ID
  assign pkt.valid    = 1'b1;
  assign pkt.pc       = pc;
  assign pkt.pc_plus4 = pc_plus4;
  assign pkt.instr    = imem_rdata;
  assign pkt.pred     = pred;

  // Next PC guess
  // Return via RAS first, then taken BTB hit, else fall through
  always_comb begin
    if (btb_hit && btb_is_return && ras_valid) begin
      next_pc_pred = ras_target;
    end else if (btb_hit && btb_taken) begin
      next_pc_pred = btb_target;
    end else begin
      next_pc_pred = pc_plus4;
    end
  end

endmodule

/* logic/if_id_reg.sv */
`timescale 1ns/1ps

module if_id_reg (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stall,
  input  logic                  flush,
  input  fetch_pkg::fetch_pkt_t pkt_in,
  output fetch_pkg::fetch_pkt_t pkt_out
);

  import fetch_pkg::*;

  // Flush beats stall
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      // Invalid slot carrying a NOP
      pkt_out       <= '0;
      pkt_out.instr <= I_NOP;
    end else if (!stall) begin
      pkt_out <= pkt_in;
    end
  end

endmodule

/* logic/fetch_front_end.sv */
`timescale 1ns/1ps

module fetch_front_end (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stall,
  input  fetch_pkg::resolve_t   resolve,
  output fetch_pkg::xlen_t      imem_raddr,
  input  fetch_pkg::instr_t     imem_rdata,
  output fetch_pkg::fetch_pkt_t id_pkt
);

  import fetch_pkg::*;

  xlen_t      pc;
  xlen_t      next_pc_pred;
  logic       btb_hit;
  logic       btb_taken;
  logic       btb_is_return;
  xlen_t      btb_target;
  xlen_t      ras_top;
  logic       ras_valid;
  fetch_pkt_t if_pkt;
  logic       flush;

  // Mispredict kills the packet being fetched
  assign flush = resolve.valid && resolve.redirect;

  pc_gen u_pc_gen (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .resolve      (resolve),
    .next_pc_pred (next_pc_pred),
    .pc           (pc)
  );

  branch_target_buffer u_btb (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .resolve   (resolve),
    .hit       (btb_hit),
    .taken     (btb_taken),
    .is_return (btb_is_return),
    .target    (btb_target)
  );

  return_stack u_ras (
    .clk       (clk),
    .rst       (rst),
    .resolve   (resolve),
    .top       (ras_top),
    .top_valid (ras_valid)
  );

  fetch_stage_sram u_fetch (
    .pc            (pc),
    .imem_raddr    (imem_raddr),
    .imem_rdata    (imem_rdata),
    .btb_hit       (btb_hit),
    .btb_taken     (btb_taken),
    .btb_is_return (btb_is_return),
    .btb_target    (btb_target),
    .ras_valid     (ras_valid),
    .ras_target    (ras_top),
    .pkt           (if_pkt),
    .next_pc_pred  (next_pc_pred)
  );

  // Only registered stage between SRAM and decode
  if_id_reg u_if_id (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .flush   (flush),
    .pkt_in  (if_pkt),
    .pkt_out (id_pkt)
  );

endmodule

/* bench/fetch_clock_gen.sv */
`timescale 1ns/1ps

module fetch_clock_gen (
  output logic clk
);

  // 100 ns period, starts low
  initial begin
    clk = 1'b0;
  end

  always begin
    #50 clk = ~clk;
  end

endmodule

/* bench/fetch_front_end_tb.sv */
`timescale 1ns/1ps

module fetch_front_end_tb;

  import fetch_pkg::*;

  // Run length, in clock cycles
  localparam int RESET_CYCLES    = 10;
  localparam int DIRECTED_CYCLES = 110;
  localparam int MIX_CYCLES      = 400;
  // Whole run plus 20 cycles of slack, in ns
  localparam int WATCHDOG_NS =
    (RESET_CYCLES + DIRECTED_CYCLES + MIX_CYCLES + 20) * 100;

  logic       clk;
  logic       rst;
  logic       stall;
  resolve_t   resolve;
  xlen_t      imem_raddr;
  instr_t     imem_rdata;
  fetch_pkt_t id_pkt;

  // 256-word SRAM, answers in the same cycle
  instr_t mem [256];
  assign imem_rdata = mem[imem_raddr[9:2]];

  // Reference state
  xlen_t      m_pc;
  fetch_pkt_t m_pkt;
  logic       m_btb_valid  [BTB_ENTRIES];
  btb_tag_t   m_btb_tag    [BTB_ENTRIES];
  xlen_t      m_btb_target [BTB_ENTRIES];
  logic       m_btb_taken  [BTB_ENTRIES];
  logic       m_btb_ret    [BTB_ENTRIES];
  xlen_t      m_ras        [RAS_DEPTH];
  ras_ptr_t   m_ras_ptr;
  int         m_ras_cnt;
  fetch_pkt_t exp_pkt;

  // Score keeping
  int checks;
  int mismatches;
  int test_start;
  int tests_run;
  int tests_failed;

  fetch_clock_gen i_clock_gen (
    .clk (clk)
  );

  fetch_front_end i_fetch_front_end (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .resolve    (resolve),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .id_pkt     (id_pkt)
  );

  // Model after reset: bubble in IF/ID, empty predictors
  task automatic reset_model();
    m_pc = RESET_PC;
    m_pkt = '0;
    m_pkt.instr = I_NOP;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_btb_valid[i] = 1'b0;
    end
    m_ras_ptr = '0;
    m_ras_cnt = 0;
  endtask

  // One clock edge of the front end, returns the new IF/ID contents
  function automatic fetch_pkt_t step_model(input logic stall_in, input resolve_t rs);
    fetch_pkt_t cur;
    logic [3:0] idx;
    logic [3:0] widx;
    logic       hit;
    logic       whit;
    xlen_t      next;
    // Packet that fetch builds for the current PC
    idx = m_pc[5:2];
    hit = m_btb_valid[idx] && (m_btb_tag[idx] == m_pc[31:6]);
    cur.valid = 1'b1;
    cur.pc = m_pc;
    cur.pc_plus4 = m_pc + 32'd4;
    cur.instr = mem[m_pc[9:2]];
    cur.pred.btb_hit = hit;
    cur.pred.pred_taken = hit && m_btb_taken[idx];
    cur.pred.btb_target = m_btb_target[idx];
    cur.pred.is_return = hit && m_btb_ret[idx];
    cur.pred.ras_valid = (m_ras_cnt != 0);
    cur.pred.ras_target = m_ras[m_ras_ptr];
    // Return via stack, then taken hit, then fall through
    if (cur.pred.is_return && cur.pred.ras_valid) begin
      next = cur.pred.ras_target;
    end else if (cur.pred.pred_taken) begin
      next = m_btb_target[idx];
    end else begin
      next = cur.pc_plus4;
    end
    // Redirect flushes and wins over stall
    if (rs.valid && rs.redirect) begin
      m_pkt = '0;
      m_pkt.instr = I_NOP;
      m_pc = rs.redirect_pc;
    end else if (!stall_in) begin
      m_pkt = cur;
      m_pc = next;
    end
    // BTB training
    widx = rs.pc[5:2];
    whit = m_btb_valid[widx] && (m_btb_tag[widx] == rs.pc[31:6]);
    if (rs.valid && (rs.taken || rs.is_return)) begin
      m_btb_valid[widx] = 1'b1;
      m_btb_tag[widx] = rs.pc[31:6];
      m_btb_target[widx] = rs.target;
      m_btb_taken[widx] = 1'b1;
      m_btb_ret[widx] = rs.is_return;
    end else if (rs.valid && whit) begin
      m_btb_taken[widx] = 1'b0;
    end
    // Calls push, returns pop, full stack overwrites the oldest
    if (rs.valid && rs.is_call) begin
      m_ras_ptr = m_ras_ptr + 2'd1;
      m_ras[m_ras_ptr] = rs.pc + 32'd4;
      if (m_ras_cnt < RAS_DEPTH) begin
        m_ras_cnt = m_ras_cnt + 1;
      end
    end else if (rs.valid && rs.is_return && m_ras_cnt != 0) begin
      m_ras_ptr = m_ras_ptr - 2'd1;
      m_ras_cnt = m_ras_cnt - 1;
    end
    return m_pkt;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      mismatches++;
      $display("MISMATCH t=%0t %s expected 0x%08h actual 0x%08h",
               $time, name, exp_v, act_v);
    end
  endtask

  task automatic compare_pkt();
    check_field("id_pkt.valid", 32'(exp_pkt.valid), 32'(id_pkt.valid));
    check_field("id_pkt.pc", exp_pkt.pc, id_pkt.pc);
    check_field("id_pkt.pc_plus4", exp_pkt.pc_plus4, id_pkt.pc_plus4);
    check_field("id_pkt.instr", exp_pkt.instr, id_pkt.instr);
    check_field("id_pkt.pred.btb_hit", 32'(exp_pkt.pred.btb_hit),
                32'(id_pkt.pred.btb_hit));
    check_field("id_pkt.pred.pred_taken", 32'(exp_pkt.pred.pred_taken),
                32'(id_pkt.pred.pred_taken));
    check_field("id_pkt.pred.is_return", 32'(exp_pkt.pred.is_return),
                32'(id_pkt.pred.is_return));
    check_field("id_pkt.pred.ras_valid", 32'(exp_pkt.pred.ras_valid),
                32'(id_pkt.pred.ras_valid));
    // Targets carry no meaning without their valid flag
    if (exp_pkt.pred.btb_hit) begin
      check_field("id_pkt.pred.btb_target", exp_pkt.pred.btb_target,
                  id_pkt.pred.btb_target);
    end
    if (exp_pkt.pred.ras_valid) begin
      check_field("id_pkt.pred.ras_target", exp_pkt.pred.ras_target,
                  id_pkt.pred.ras_target);
    end
  endtask

  // Step the model on each edge, compare once the registers settled
  always @(posedge clk) begin
    if (rst) begin
      reset_model();
      exp_pkt = m_pkt;
    end else begin
      exp_pkt = step_model(stall, resolve);
    end
    #1;
    compare_pkt();
    // PC as seen on the SRAM address port
    check_field("imem_raddr", m_pc, imem_raddr);
  end

  // Inputs change on the falling edge only
  task automatic drive_cycle(input logic stall_v, input resolve_t rs_v);
    @(negedge clk);
    stall = stall_v;
    resolve = rs_v;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0);
  endtask

  function automatic resolve_t make_resolve(input xlen_t pc, input xlen_t target,
                                            input logic taken, input logic is_call,
                                            input logic is_return, input logic redirect,
                                            input xlen_t redirect_pc);
    resolve_t rs;
    rs.valid = 1'b1;
    rs.pc = pc;
    rs.target = target;
    rs.taken = taken;
    rs.is_call = is_call;
    rs.is_return = is_return;
    rs.redirect = redirect;
    rs.redirect_pc = redirect_pc;
    return rs;
  endfunction

  // Word-aligned PC in a small window so the BTB sees reuse
  function automatic xlen_t random_pc();
    return 32'h0000_0100 + (($urandom % 32) << 2);
  endfunction

  task automatic random_mix(input int n);
    resolve_t rs;
    for (int i = 0; i < n; i++) begin
      rs = '0;
      if (($urandom % 4) == 0) begin
        rs.valid = 1'b1;
        rs.pc = random_pc();
        rs.target = random_pc();
        rs.taken = ($urandom % 2) == 0;
        rs.is_call = ($urandom % 6) == 0;
        rs.is_return = ($urandom % 6) == 0;
        rs.redirect = ($urandom % 3) == 0;
        rs.redirect_pc = random_pc();
      end
      drive_cycle(($urandom % 4) == 0, rs);
    end
  endtask

  task automatic begin_test();
    test_start = mismatches;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (mismatches == test_start) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d mismatches", name, mismatches - test_start);
    end
  endtask

  initial begin
    rst = 1'b1;
    stall = 1'b0;
    resolve = '0;
    checks = 0;
    mismatches = 0;
    tests_run = 0;
    tests_failed = 0;
    void'($urandom(29));
    for (int i = 0; i < 256; i++) begin
      mem[i] = $urandom;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;

    // First packet after reset, then straight-line fetch
    begin_test();
    drive_cycle(1'b0, '0);
    check_field("id_pkt.valid", 32'd1, 32'(id_pkt.valid));
    check_field("id_pkt.pc", RESET_PC, id_pkt.pc);
    idle_cycles(20);
    end_test("sequential");

    begin_test();
    repeat (40) drive_cycle(($urandom % 3) == 0, '0);
    idle_cycles(3);
    end_test("stall");

    // Second redirect arrives under stall
    begin_test();
    drive_cycle(1'b0, make_resolve(32'h180, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h200));
    idle_cycles(4);
    drive_cycle(1'b1, make_resolve(32'h210, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h340));
    drive_cycle(1'b1, '0);
    drive_cycle(1'b1, '0);
    idle_cycles(4);
    end_test("redirect");

    // Train A=0x400 to 0x480, run through it, then untrain
    begin_test();
    drive_cycle(1'b0, make_resolve(32'h400, 32'h480, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0));
    drive_cycle(1'b0, make_resolve(32'h3f0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h3f8));
    idle_cycles(6);
    drive_cycle(1'b0, make_resolve(32'h400, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h3f8));
    idle_cycles(6);
    end_test("btb_training");

    // Push 0x504 and 0x608, pop at 0x720, fetch 0x720 goes to 0x504
    begin_test();
    drive_cycle(1'b0, make_resolve(32'h500, 32'h600, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0));
    drive_cycle(1'b0, make_resolve(32'h604, 32'h700, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0));
    drive_cycle(1'b0, make_resolve(32'h720, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0));
    drive_cycle(1'b0, make_resolve(32'h6f0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h71c));
    idle_cycles(6);
    end_test("return_stack");

    begin_test();
    random_mix(MIX_CYCLES);
    idle_cycles(2);
    end_test("random_mix");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
             tests_run, tests_failed, checks, mismatches);
    if (mismatches == 0 && tests_failed == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Ends a run that stopped making progress
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* sim.f */
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/branch_target_buffer.sv
logic/return_stack.sv
logic/fetch_stage_sram.sv
logic/if_id_reg.sv
logic/fetch_front_end.sv
bench/fetch_clock_gen.sv
bench/fetch_front_end_tb.sv

/* Makefile */
TOP = fetch_front_end_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f logic/*.sv bench/*.sv
	verilator --binary --timing -f sim.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "NO ERRORS" sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)
	verilator --lint-only -Wall logic/fetch_pkg.sv logic/pc_gen.sv \
		logic/branch_target_buffer.sv logic/return_stack.sv \
		logic/fetch_stage_sram.sv logic/if_id_reg.sv logic/fetch_front_end.sv \
		--top-module fetch_front_end

clean:
	rm -rf obj_dir sim.log
